/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := winRateTb
FILELIST := project.f
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* logic/boardIf.sv */
// one enumerated board plus the latched hole ranks of every player
// boardValid is a level, boardLast marks the final board of a job

interface boardIf #(
    parameter int numPlayers = 9
);
    import winRatePkg::*;

    logic boardValid;
    logic boardLast;
    // public cards in [2:0], drawn pair in [4:3]
    cardRankT [publicCards+boardDrawn-1:0] boardRanks;
    // player p owns entries 2p and 2p+1
    cardRankT [2*numPlayers-1:0] holeRanks;

    modport src (
        output boardValid, boardLast, boardRanks, holeRanks
    );

    modport snk (
        input boardValid, boardLast, boardRanks, holeRanks
    );

endinterface

/* logic/cardEnumerator.sv */
// latches a deal on startStrobe and sends one board per cycle over all
// unordered pairs of unseen cards; a strobe while busy is dropped,
// except alongside the last board, where the next job starts directly

module cardEnumerator #(
    parameter int numPlayers = 9
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    startStrobe,
    input  logic [8*numPlayers-1:0]                 holeNum,
    input  logic [4*numPlayers-1:0]                 holeSuit,
    input  logic [4*winRatePkg::publicCards-1:0]    pubNum,
    input  logic [2*winRatePkg::publicCards-1:0]    pubSuit,
    boardIf.src                                     board
);
    import winRatePkg::*;

    localparam int holeCount = 2 * numPlayers;

    deckMaskT unseenMask;
    deckMaskT firstMask;
    deckMaskT secondMask;
    deckMaskT firstRest;
    cardRankT firstRank;
    cardRankT secondRank;
    cardRankT [holeCount-1:0]   holeRankQ;
    cardRankT [publicCards-1:0] pubRankQ;
    logic active;
    logic lastPair;
    logic accept;

    function automatic cardIdxT cardIndex(cardSuitT suit, cardRankT rank);
        return cardIdxT'(suit) * cardIdxT'(13) + cardIdxT'(rank) - cardIdxT'(2);
    endfunction

    function automatic deckMaskT lowestBit(deckMaskT m);
        return m & (~m + deckMaskT'(1));
    endfunction

    function automatic deckMaskT dropLowest(deckMaskT m);
        return m & (m - deckMaskT'(1));
    endfunction

    // one-hot deck position to rank
    function automatic cardRankT bitRank(deckMaskT oneHot);
        cardRankT rank;
        rank = '0;
        for (int i = 0; i < deckSize; i++) begin
            if (oneHot[i]) begin
                rank = rank | cardRankT'(i % 13 + 2);
            end
        end
        return rank;
    endfunction

    // ========================================================================
    // unseen deck from the 21 dealt cards
    // ========================================================================
    always_comb begin
        unseenMask = '1;
        for (int j = 0; j < holeCount; j++) begin
            unseenMask[cardIndex(holeSuit[2*j +: 2], holeNum[4*j +: 4])] = 1'b0;
        end
        for (int j = 0; j < publicCards; j++) begin
            unseenMask[cardIndex(pubSuit[2*j +: 2], pubNum[4*j +: 4])] = 1'b0;
        end
    end

    assign accept = startStrobe && (!active || lastPair);

    // last pair once the first mask is down to two cards
    assign firstRest = dropLowest(firstMask);
    assign lastPair  = active && (firstRest != '0) && (dropLowest(firstRest) == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (accept) begin
            active <= 1'b1;
        end else if (lastPair) begin
            active <= 1'b0;
        end
    end

    // ========================================================================
    // pair walk: first card = lowest of firstMask, second = lowest of
    // secondMask, which only holds cards above the first
    // ========================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            firstMask  <= unseenMask;
            secondMask <= dropLowest(unseenMask);
            holeRankQ  <= holeNum;
            pubRankQ   <= pubNum;
        end else if (active) begin
            if (dropLowest(secondMask) == '0) begin
                // second card exhausted, advance the first
                firstMask  <= firstRest;
                secondMask <= dropLowest(firstRest);
            end else begin
                secondMask <= dropLowest(secondMask);
            end
        end
    end

    assign firstRank  = bitRank(lowestBit(firstMask));
    assign secondRank = bitRank(lowestBit(secondMask));

    assign board.boardValid = active;
    assign board.boardLast  = lastPair;
    assign board.boardRanks = {secondRank, firstRank, pubRankQ};
    assign board.holeRanks  = holeRankQ;

endmodule

/* logic/handScorer.sv */
// reduced scorer: quads, full house, trips, two pair, pair, high card
// key rank is the highest rank holding the largest count; no kickers
// one cycle of latency from the board to score

module handScorer #(
    parameter int playerIdx = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    boardIf.snk                   board,
    output winRatePkg::handScoreT score
);
    import winRatePkg::*;

    cardRankT   hand [handCards];
    logic [2:0] maxCount;
    // ranks with two or more cards
    logic [2:0] multiRanks;
    cardRankT   keyRank;
    logic [2:0] category;

    // own hole cards, then the five board cards
    always_comb begin
        hand[0] = board.holeRanks[2*playerIdx];
        hand[1] = board.holeRanks[2*playerIdx+1];
        for (int c = 0; c < handCards - 2; c++) begin
            hand[c+2] = board.boardRanks[c];
        end
    end

    // count each rank; walking upward with >= keeps the highest tie
    always_comb begin
        logic [2:0] cnt;
        maxCount   = '0;
        multiRanks = '0;
        keyRank    = '0;
        for (int r = 2; r <= 14; r++) begin
            cnt = '0;
            for (int c = 0; c < handCards; c++) begin
                if (hand[c] == cardRankT'(r)) begin
                    cnt = cnt + 3'd1;
                end
            end
            if (cnt >= 3'd2) begin
                multiRanks = multiRanks + 3'd1;
            end
            if (cnt >= maxCount) begin
                maxCount = cnt;
                keyRank  = cardRankT'(r);
            end
        end
    end

    always_comb begin
        if (maxCount >= 3'd4) begin
            category = 3'd5;
        end else if (maxCount == 3'd3 && multiRanks >= 3'd2) begin
            category = 3'd4;
        end else if (maxCount == 3'd3) begin
            category = 3'd3;
        end else if (multiRanks >= 3'd2) begin
            category = 3'd2;
        end else if (maxCount == 3'd2) begin
            category = 3'd1;
        end else begin
            category = 3'd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else begin
            score <= {category, keyRank};
        end
    end

endmodule

/* logic/winRate.sv */
// hold'em win-rate engine, result 467 cycles after the accepted in_valid
// in_valid while a job runs is ignored until its last board
// card fields are 4-bit ranks and 2-bit suits, player 0 in the low bits

module winRate #(
    parameter int numPlayers = 9
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic [8*numPlayers-1:0]              in_hole_num,
    input  logic [4*numPlayers-1:0]              in_hole_suit,
    input  logic [4*winRatePkg::publicCards-1:0] in_pub_num,
    input  logic [2*winRatePkg::publicCards-1:0] in_pub_suit,
    output logic                                 out_valid,
    output logic [7*numPlayers-1:0]              out_win_rate
);
    import winRatePkg::*;

    handScoreT [numPlayers-1:0] playerScores;

    boardIf #(.numPlayers(numPlayers)) boardBus ();

    cardEnumerator #(.numPlayers(numPlayers)) enumerator (
        .clk         (clk),
        .rst_n       (rst_n),
        .startStrobe (in_valid),
        .holeNum     (in_hole_num),
        .holeSuit    (in_hole_suit),
        .pubNum      (in_pub_num),
        .pubSuit     (in_pub_suit),
        .board       (boardBus.src)
    );

    // one scorer per seat, all on the same board
    for (genvar p = 0; p < numPlayers; p++) begin : gScorer
        handScorer #(.playerIdx(p)) scorer (
            .clk   (clk),
            .rst_n (rst_n),
            .board (boardBus.snk),
            .score (playerScores[p])
        );
    end

    winTally #(.numPlayers(numPlayers)) tally (
        .clk      (clk),
        .rst_n    (rst_n),
        .board    (boardBus.snk),
        .scores   (playerScores),
        .winValid (out_valid),
        .winRates (out_win_rate)
    );

endmodule

/* logic/winRatePkg.sv */
// shared types and constants for the hold'em win-rate engine
// suits only identify cards; scoring looks at rank counts alone
// fullShare is the least common multiple of 1..9, so every split is exact

package winRatePkg;

    // ========================================================================
    // deck geometry
    // ========================================================================
    localparam int deckSize    = 52;
    localparam int boardDrawn  = 2;
    localparam int publicCards = 3;
    localparam int handCards   = 7;

    // one board worth of win, divisible by any winner count up to 9
    localparam int fullShare = 2520;

    // ========================================================================
    // card and result types
    // ========================================================================
    // rank 2..14, ace high
    typedef logic [3:0] cardRankT;
    typedef logic [1:0] cardSuitT;
    // suit*13 + rank - 2
    typedef logic [5:0] cardIdxT;
    typedef logic [deckSize-1:0] deckMaskT;

    // category in [6:4], key rank in [3:0]
    typedef logic [6:0]  handScoreT;
    typedef logic [11:0] shareT;
    // up to 465 boards of fullShare
    typedef logic [20:0] winSumT;
    typedef logic [6:0]  winPctT;

    // share per winner, indexed by winner count; entry 0 never taken
    localparam shareT shareLut [0:9] = '{
        shareT'(0),
        shareT'(fullShare / 1),
        shareT'(fullShare / 2),
        shareT'(fullShare / 3),
        shareT'(fullShare / 4),
        shareT'(fullShare / 5),
        shareT'(fullShare / 6),
        shareT'(fullShare / 7),
        shareT'(fullShare / 8),
        shareT'(fullShare / 9)
    };

endpackage

/* logic/winTally.sv */
// splits each board among the tied best scores and sums the shares
// result is registered two cycles after the last score; winRates is zero
// outside the winValid cycle

module winTally #(
    parameter int numPlayers = 9
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    boardIf.snk                                   board,
    input  winRatePkg::handScoreT [numPlayers-1:0] scores,
    output logic                                  winValid,
    output winRatePkg::winPctT    [numPlayers-1:0] winRates
);
    import winRatePkg::*;

    localparam int unseenCards = deckSize - 2 * numPlayers - publicCards;
    localparam int boardsCount = unseenCards * (unseenCards - 1) / boardDrawn;
    // sum reached by a player who wins every board alone
    localparam int totalShare  = boardsCount * fullShare;
    localparam int countBits   = $clog2(numPlayers + 1);

    logic                  scoreValid;
    logic                  scoreLast;
    logic                  holdValid;
    handScoreT             bestScore;
    logic [numPlayers-1:0] winnerMask;
    logic [countBits-1:0]  winnerCount;
    shareT                 share;
    winSumT                accSum  [numPlayers];
    winSumT                holdSum [numPlayers];

    // ========================================================================
    // winners of the current board
    // ========================================================================
    always_comb begin
        bestScore = '0;
        for (int i = 0; i < numPlayers; i++) begin
            if (scores[i] > bestScore) begin
                bestScore = scores[i];
            end
        end
    end

    always_comb begin
        winnerCount = '0;
        for (int i = 0; i < numPlayers; i++) begin
            winnerMask[i] = (scores[i] == bestScore);
            winnerCount   = winnerCount + countBits'(winnerMask[i]);
        end
        share = shareLut[winnerCount];
    end

    // board strobes line up with the registered scores
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scoreValid <= 1'b0;
            scoreLast  <= 1'b0;
            holdValid  <= 1'b0;
        end else begin
            scoreValid <= board.boardValid;
            scoreLast  <= board.boardLast;
            holdValid  <= scoreValid && scoreLast;
        end
    end

    // ========================================================================
    // accumulation; the last board lands in holdSum, next job starts at zero
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < numPlayers; i++) begin
                accSum[i] <= '0;
            end
        end else if (scoreValid) begin
            for (int i = 0; i < numPlayers; i++) begin
                if (scoreLast) begin
                    accSum[i] <= '0;
                end else if (winnerMask[i]) begin
                    accSum[i] <= accSum[i] + winSumT'(share);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scoreValid && scoreLast) begin
            for (int i = 0; i < numPlayers; i++) begin
                holdSum[i] <= winnerMask[i] ? accSum[i] + winSumT'(share) : accSum[i];
            end
        end
    end

    // integer percentage, truncated
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            winValid <= 1'b0;
            winRates <= '0;
        end else begin
            winValid <= holdValid;
            for (int i = 0; i < numPlayers; i++) begin
                if (holdValid) begin
                    winRates[i] <= winPctT'((28'(holdSum[i]) * 28'd100) / 28'(totalShare));
                end else begin
                    winRates[i] <= '0;
                end
            end
        end
    end

endmodule

/* project.f */
logic/winRatePkg.sv
logic/boardIf.sv
logic/cardEnumerator.sv
logic/handScorer.sv
logic/winTally.sv
logic/winRate.sv
verif/winRateTb.sv

/* verif/winRateTb.sv */
// testbench for the win-rate engine with nine players
// expected words come from a behavioral model of the reduced rank-count scorer
// one result per accepted deal, checked in order of acceptance

module winRateTb;
    timeunit 1ns;
    timeprecision 1ps;

    // six jobs at up to 500 cycles each, plus reset and idle gaps
    localparam int numJobs       = 6;
    localparam int timeoutCycles = numJobs * 500 + 500;
    localparam int resultLatency = 467;

    typedef struct packed {
        logic [71:0] holeNum;
        logic [35:0] holeSuit;
        logic [11:0] pubNum;
        logic [5:0]  pubSuit;
    } dealT;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [71:0] in_hole_num;
    logic [35:0] in_hole_suit;
    logic [11:0] in_pub_num;
    logic [5:0]  in_pub_suit;
    logic        out_valid;
    logic [62:0] out_win_rate;

    int          seed;
    int          cycle = 0;
    logic        prevValid = 1'b0;
    logic [62:0] expWord[$];
    int          expStart[$];
    string       expName[$];

    winRate dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hole_num  (in_hole_num),
        .in_hole_suit (in_hole_suit),
        .in_pub_num   (in_pub_num),
        .in_pub_suit  (in_pub_suit),
        .out_valid    (out_valid),
        .out_win_rate (out_win_rate)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // reference model
    // ========================================================================
    // category*16 + highest rank among those with the largest count
    function automatic int handValue(input int cnt[15]);
        int maxC;
        int multi;
        int key;
        int cat;
        maxC  = 0;
        multi = 0;
        key   = 0;
        for (int r = 2; r <= 14; r++) begin
            if (cnt[r] > maxC) maxC = cnt[r];
            if (cnt[r] >= 2) multi++;
        end
        for (int r = 2; r <= 14; r++) begin
            if (cnt[r] == maxC) key = r;
        end
        if (maxC >= 4) cat = 5;
        else if (maxC == 3 && multi >= 2) cat = 4;
        else if (maxC == 3) cat = 3;
        else if (multi >= 2) cat = 2;
        else if (maxC == 2) cat = 1;
        else cat = 0;
        return cat * 16 + key;
    endfunction

    function automatic logic [62:0] refWinRates(input dealT d);
        logic [51:0] seen;
        logic [62:0] word;
        int rank[21];
        int cnt[15];
        int sums[9];
        int score[9];
        int r;
        int s;
        int best;
        int winners;
        int boards;
        seen   = '0;
        boards = 0;
        for (int c = 0; c < 21; c++) begin
            if (c < 18) begin
                r = int'(d.holeNum[4*c +: 4]);
                s = int'(d.holeSuit[2*c +: 2]);
            end else begin
                r = int'(d.pubNum[4*(c-18) +: 4]);
                s = int'(d.pubSuit[2*(c-18) +: 2]);
            end
            rank[c] = r;
            seen[s*13 + r - 2] = 1'b1;
        end
        for (int p = 0; p < 9; p++) sums[p] = 0;
        // every unordered pair of unseen cards completes the board
        for (int a = 0; a < 52; a++) begin
            for (int b = a + 1; b < 52; b++) begin
                if (!seen[a] && !seen[b]) begin
                    boards++;
                    best = -1;
                    for (int p = 0; p < 9; p++) begin
                        for (int k = 0; k < 15; k++) cnt[k] = 0;
                        for (int k = 18; k < 21; k++) cnt[rank[k]]++;
                        cnt[a % 13 + 2]++;
                        cnt[b % 13 + 2]++;
                        cnt[rank[2*p]]++;
                        cnt[rank[2*p+1]]++;
                        score[p] = handValue(cnt);
                        if (score[p] > best) best = score[p];
                    end
                    winners = 0;
                    for (int p = 0; p < 9; p++) begin
                        if (score[p] == best) winners++;
                    end
                    for (int p = 0; p < 9; p++) begin
                        if (score[p] == best) sums[p] += 2520 / winners;
                    end
                end
            end
        end
        for (int p = 0; p < 9; p++) begin
            word[7*p +: 7] = 7'(sums[p] * 100 / (boards * 2520));
        end
        return word;
    endfunction

    // ========================================================================
    // stimulus helpers
    // ========================================================================
    // deck index = suit*13 + rank - 2; slots 0..17 hole, 18..20 public
    function automatic dealT placeCard(input dealT d, input int slot, input int idx);
        dealT q;
        q = d;
        if (slot < 18) begin
            q.holeNum[4*slot +: 4]  = 4'(idx % 13 + 2);
            q.holeSuit[2*slot +: 2] = 2'(idx / 13);
        end else begin
            q.pubNum[4*(slot-18) +: 4]  = 4'(idx % 13 + 2);
            q.pubSuit[2*(slot-18) +: 2] = 2'(idx / 13);
        end
        return q;
    endfunction

    task automatic randomDeal(output dealT d);
        int deck[52];
        int j;
        int tmp;
        for (int i = 0; i < 52; i++) deck[i] = i;
        for (int i = 51; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp = deck[i];
            deck[i] = deck[j];
            deck[j] = tmp;
        end
        d = '0;
        for (int c = 0; c < 21; c++) d = placeCard(d, c, deck[c]);
    endtask

    task automatic applyDeal(input dealT d);
        in_hole_num  = d.holeNum;
        in_hole_suit = d.holeSuit;
        in_pub_num   = d.pubNum;
        in_pub_suit  = d.pubSuit;
    endtask

    // call on a falling edge; the deal is sampled at the next rising edge
    task automatic startJob(input dealT d, input string name);
        applyDeal(d);
        in_valid = 1'b1;
        expWord.push_back(refWinRates(d));
        expStart.push_back(cycle + 1);
        expName.push_back(name);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // strobe that the busy enumerator must drop
    task automatic pulseBusy(input dealT d);
        applyDeal(d);
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic waitUntilCycle(input int target);
        while (cycle < target) @(negedge clk);
    endtask

    task automatic waitIdle();
        while (expWord.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0h actual %0h", testName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // ========================================================================
    // cycle count, timeout and output compare
    // ========================================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeoutCycles) begin
            $display("timeout: no end of test after %0d cycles", timeoutCycles);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (prevValid) checkValue("out_valid pulse length", 64'(0), 64'(out_valid));
        if (out_valid) begin
            if (expWord.size() == 0) begin
                $display("out_valid pulsed while no job was pending");
                $display("Simulation FAILED");
                $fatal(1);
            end else begin
                checkValue({expName[0], " latency"}, 64'(expStart[0] + resultLatency),
                           64'(cycle));
                checkValue(expName[0], 64'(expWord[0]), 64'(out_win_rate));
                void'(expWord.pop_front());
                void'(expStart.pop_front());
                void'(expName.pop_front());
            end
        end else begin
            checkValue("idle output", 64'(0), 64'(out_win_rate));
        end
        prevValid = out_valid;
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        dealT dealA;
        dealT dealB;
        int   startCycle;
        seed         = 74;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_hole_num  = '0;
        in_hole_suit = '0;
        in_pub_num   = '0;
        in_pub_suit  = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        for (int t = 0; t < 2; t++) begin
            randomDeal(dealA);
            startJob(dealA, "random deal");
            waitIdle();
        end

        // strobes sampled at E1, E200 and E464 must be dropped
        randomDeal(dealA);
        randomDeal(dealB);
        startCycle = cycle + 1;
        startJob(dealA, "busy job");
        pulseBusy(dealB);
        waitUntilCycle(startCycle + 199);
        pulseBusy(dealB);
        waitUntilCycle(startCycle + 463);
        pulseBusy(dealB);
        waitIdle();

        // second deal sampled at E465 of the first
        randomDeal(dealA);
        randomDeal(dealB);
        startCycle = cycle + 1;
        startJob(dealA, "overlap first");
        waitUntilCycle(startCycle + 464);
        startJob(dealB, "overlap second");
        waitIdle();

        // public aces of clubs and diamonds plus the seven of hearts
        dealA = '0;
        for (int p = 0; p < 9; p++) begin
            dealA = placeCard(dealA, 2*p, p);
            dealA = placeCard(dealA, 2*p + 1, 39 + (p + 4) % 9);
        end
        dealA = placeCard(dealA, 18, 12);
        dealA = placeCard(dealA, 19, 25);
        dealA = placeCard(dealA, 20, 31);
        startJob(dealA, "public ace pair");
        waitIdle();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
